// ==== Makefile ====
# Verilator flow for the FEC ingress block.
# Any variable can be set on the command line, e.g. make sim TOP=tb_fec_igr

VERILATOR  ?= verilator
TOP        ?= tb_fec_igr
RTL_TOP    ?= fec_igr_top
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG   ?= Simulation PASSED

.PHONY: all lint lint_rtl build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

lint_rtl:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the output.
sim: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
fec_pkg.sv
pipe_stage.sv
igr_demux.sv
fec_encode.sv
fec_err_inject.sv
fec_decode.sv
fec_igr_top.sv
tb_fec_igr.sv

// ==== fec_decode.sv ====
`timescale 1ns/1ps

module fec_decode #(
    parameter int FEC_K = 4
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  fec_pkg::fec_word_t                  in_word,
    input  logic                                in_valid,
    output logic                                in_ready,
    input  logic                                dec_en,
    input  logic [fec_pkg::loc_wid(FEC_K)-1:0]  err_loc_dec,
    output fec_pkg::axis_beat_t                 out_beat,
    output logic                                out_valid,
    input  logic                                out_ready
);
    import fec_pkg::*;

    localparam int LOC_WID = loc_wid(FEC_K);
    localparam int WR_WID  = $clog2(FEC_K + 1);    // counts up to FEC_K.

    axis_beat_t          blk_mem [FEC_K];   // data beats of one block.
    logic [WR_WID-1:0]   wr_cnt;
    logic [LOC_WID-1:0]  rd_cnt;
    logic [data_wid-1:0] syndrome;          // xor of data and parity.
    logic                draining;
    logic                in_xfer;
    logic                out_xfer;

    assign in_ready  = !draining;   // no new block while draining.
    assign in_xfer   = in_valid && in_ready;
    assign out_xfer  = out_valid && out_ready;
    assign out_valid = draining;

    // ------------------------------------------------------------------
    // fill side.
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (in_xfer && !in_word.is_parity) begin
            blk_mem[LOC_WID'(wr_cnt)] <= in_word.beat;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt   <= '0;
            rd_cnt   <= '0;
            syndrome <= '0;
            draining <= 1'b0;
        end else if (!draining) begin
            if (in_xfer) begin
                syndrome <= syndrome ^ in_word.beat.tdata;
                if (in_word.is_parity) begin
                    wr_cnt   <= '0;
                    draining <= 1'b1;   // block complete.
                end else begin
                    wr_cnt <= wr_cnt + 1'b1;
                end
            end
        end else if (out_xfer) begin
            if (rd_cnt == LOC_WID'(FEC_K - 1)) begin
                rd_cnt   <= '0;
                syndrome <= '0;
                draining <= 1'b0;
            end else begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // drain side. rebuild one beat from the syndrome.
    // ------------------------------------------------------------------
    always_comb begin
        out_beat = blk_mem[rd_cnt];
        if (dec_en && (rd_cnt == err_loc_dec)) begin
            out_beat.tdata = blk_mem[rd_cnt].tdata ^ syndrome;
        end
    end

    // framing from the encoder: parity exactly after FEC_K data words.
    a_block_frame: assert property (@(posedge clk) disable iff (!rst_n)
        in_xfer |-> (in_word.is_parity == (wr_cnt == WR_WID'(FEC_K))))
        else $error("fec_decode: parity word out of place");

endmodule : fec_decode

// ==== fec_encode.sv ====
`timescale 1ns/1ps

module fec_encode #(
    parameter int FEC_K = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  fec_pkg::axis_beat_t  in_beat,
    input  logic                 in_valid,
    output logic                 in_ready,
    output fec_pkg::fec_word_t   out_word,
    output logic                 out_valid,
    input  logic                 out_ready
);
    import fec_pkg::*;

    localparam int LOC_WID = loc_wid(FEC_K);

    logic [LOC_WID-1:0]  beat_cnt;     // data beats taken in this block.
    logic [data_wid-1:0] par_acc;      // running xor of tdata.
    logic                par_pend;     // parity word is being offered.
    logic                in_xfer;
    logic                last_beat;

    assign in_xfer   = in_valid && in_ready;
    assign last_beat = (beat_cnt == LOC_WID'(FEC_K - 1));

    // ------------------------------------------------------------------
    // output mux. data passes through, parity is inserted.
    // ------------------------------------------------------------------
    assign in_ready  = !par_pend && out_ready;
    assign out_valid = par_pend || in_valid;

    always_comb begin
        out_word = '0;
        if (par_pend) begin
            out_word.is_parity  = 1'b1;
            out_word.beat.tdata = par_acc;
        end else begin
            out_word.beat = in_beat;
        end
    end

    // ------------------------------------------------------------------
    // block counter and parity accumulator.
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            par_acc  <= '0;
            par_pend <= 1'b0;
        end else if (par_pend) begin
            if (out_ready) begin
                par_pend <= 1'b0;
                par_acc  <= '0;     // start next block.
            end
        end else if (in_xfer) begin
            par_acc <= par_acc ^ in_beat.tdata;
            if (last_beat) begin
                beat_cnt <= '0;
                par_pend <= 1'b1;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // the block's last beat is followed by a parity cycle with no input taken.
    a_parity_slot: assert property (@(posedge clk) disable iff (!rst_n)
        in_xfer && last_beat |=> out_valid && out_word.is_parity && !in_xfer)
        else $error("fec_encode: input accepted in parity cycle");

endmodule : fec_encode

// ==== fec_err_inject.sv ====
`timescale 1ns/1ps

module fec_err_inject #(
    parameter int FEC_K = 4
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  fec_pkg::fec_word_t                  in_word,
    input  logic                                in_valid,
    output logic                                in_ready,
    input  logic                                err_inj_en,
    input  logic [fec_pkg::loc_wid(FEC_K)-1:0]  err_loc_inj,
    input  logic [fec_pkg::data_wid-1:0]        err_pat,
    output fec_pkg::fec_word_t                  out_word,
    output logic                                out_valid,
    input  logic                                out_ready
);
    import fec_pkg::*;

    localparam int LOC_WID = loc_wid(FEC_K);

    logic [LOC_WID-1:0] beat_cnt;  // data position within the block.

    assign in_ready  = out_ready;
    assign out_valid = in_valid;

    always_comb begin
        out_word = in_word;
        if (err_inj_en && !in_word.is_parity && (beat_cnt == err_loc_inj)) begin
            out_word.beat.tdata = in_word.beat.tdata ^ err_pat;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (in_valid && in_ready) begin
            // parity closes the block.
            beat_cnt <= in_word.is_parity ? '0 : beat_cnt + 1'b1;
        end
    end

endmodule : fec_err_inject

// ==== fec_igr_top.sv ====
`timescale 1ns/1ps

module fec_igr_top #(
    parameter int NUM_PORTS = 2,   // number of ingress lanes.
    parameter int FEC_K     = 4    // data beats per block.
) (
    input  logic                                clk,
    input  logic                                rst_n,

    input  fec_pkg::axis_beat_t                 in_beat   [NUM_PORTS],
    input  logic [NUM_PORTS-1:0]                in_valid,
    output logic [NUM_PORTS-1:0]                in_ready,

    output fec_pkg::axis_beat_t                 out_beat  [NUM_PORTS],
    output logic [NUM_PORTS-1:0]                out_valid,
    input  logic [NUM_PORTS-1:0]                out_ready,

    output fec_pkg::axis_beat_t                 c2h_beat  [NUM_PORTS],
    output logic [NUM_PORTS-1:0]                c2h_valid,
    input  logic [NUM_PORTS-1:0]                c2h_ready,

    input  logic                                force_c2h,
    input  logic                                err_inj_en,
    input  logic [fec_pkg::loc_wid(FEC_K)-1:0]  err_loc_inj,
    input  logic [fec_pkg::data_wid-1:0]        err_pat,
    input  logic                                dec_en,
    input  logic [fec_pkg::loc_wid(FEC_K)-1:0]  err_loc_dec
);
    import fec_pkg::*;

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        axis_beat_t dmx_fec_beat, dmx_c2h_beat, enc_in_beat;
        logic       dmx_fec_valid, dmx_fec_ready;
        logic       dmx_c2h_valid, dmx_c2h_ready;
        logic       enc_in_valid, enc_in_ready;
        fec_word_t  enc_word, inj_in_word, inj_out_word;
        logic       enc_valid, enc_ready;
        logic       inj_in_valid, inj_in_ready;
        logic       inj_out_valid, inj_out_ready;

        // --------------------------------------------------------------
        // path select and card-to-host output.
        // --------------------------------------------------------------
        igr_demux u_igr_demux (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_beat   (in_beat[i]),
            .in_valid  (in_valid[i]),
            .in_ready  (in_ready[i]),
            .force_c2h (force_c2h),
            .fec_beat  (dmx_fec_beat),
            .fec_valid (dmx_fec_valid),
            .fec_ready (dmx_fec_ready),
            .c2h_beat  (dmx_c2h_beat),
            .c2h_valid (dmx_c2h_valid),
            .c2h_ready (dmx_c2h_ready)
        );

        pipe_stage #(.T(axis_beat_t)) u_c2h_pipe (
            .clk (clk), .rst_n (rst_n),
            .in_data  (dmx_c2h_beat), .in_valid  (dmx_c2h_valid), .in_ready  (dmx_c2h_ready),
            .out_data (c2h_beat[i]),  .out_valid (c2h_valid[i]),  .out_ready (c2h_ready[i])
        );

        // --------------------------------------------------------------
        // fec loop. encode, inject, decode.
        // --------------------------------------------------------------
        pipe_stage #(.T(axis_beat_t)) u_enc_pipe (
            .clk (clk), .rst_n (rst_n),
            .in_data  (dmx_fec_beat), .in_valid  (dmx_fec_valid), .in_ready  (dmx_fec_ready),
            .out_data (enc_in_beat),  .out_valid (enc_in_valid),  .out_ready (enc_in_ready)
        );

        fec_encode #(.FEC_K(FEC_K)) u_fec_encode (
            .clk (clk), .rst_n (rst_n),
            .in_beat  (enc_in_beat), .in_valid  (enc_in_valid), .in_ready  (enc_in_ready),
            .out_word (enc_word),    .out_valid (enc_valid),    .out_ready (enc_ready)
        );

        pipe_stage #(.T(fec_word_t)) u_word_pipe (
            .clk (clk), .rst_n (rst_n),
            .in_data  (enc_word),    .in_valid  (enc_valid),    .in_ready  (enc_ready),
            .out_data (inj_in_word), .out_valid (inj_in_valid), .out_ready (inj_in_ready)
        );

        fec_err_inject #(.FEC_K(FEC_K)) u_fec_err_inject (
            .clk         (clk),
            .rst_n       (rst_n),
            .in_word     (inj_in_word),
            .in_valid    (inj_in_valid),
            .in_ready    (inj_in_ready),
            .err_inj_en  (err_inj_en),
            .err_loc_inj (err_loc_inj),
            .err_pat     (err_pat),
            .out_word    (inj_out_word),
            .out_valid   (inj_out_valid),
            .out_ready   (inj_out_ready)
        );

        fec_decode #(.FEC_K(FEC_K)) u_fec_decode (
            .clk         (clk),
            .rst_n       (rst_n),
            .in_word     (inj_out_word),
            .in_valid    (inj_out_valid),
            .in_ready    (inj_out_ready),
            .dec_en      (dec_en),
            .err_loc_dec (err_loc_dec),
            .out_beat    (out_beat[i]),
            .out_valid   (out_valid[i]),
            .out_ready   (out_ready[i])
        );
    end : g_port

endmodule : fec_igr_top

// ==== fec_pkg.sv ====
package fec_pkg;

    // ------------------------------------------------------------------
    // stream widths.
    // ------------------------------------------------------------------
    localparam int data_wid = 64;           // one data word per beat.
    localparam int keep_wid = data_wid / 8;
    localparam int id_wid   = 4;
    localparam int dest_wid = 2;
    localparam int user_wid = 8;

    // type code carried in tdest.
    typedef enum logic [dest_wid-1:0] {
        port_phy0 = 2'd0,
        port_phy1 = 2'd1,
        port_vf0  = 2'd2,   // host-bound traffic.
        port_vf1  = 2'd3
    } port_typ_e;

    // ------------------------------------------------------------------
    // stream beat and code word.
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [data_wid-1:0] tdata;
        logic [keep_wid-1:0] tkeep;
        logic [id_wid-1:0]   tid;
        logic [dest_wid-1:0] tdest;
        logic [user_wid-1:0] tuser;
        logic                tlast;
    } axis_beat_t;

    // a parity word has its xor in beat.tdata and all else zero.
    typedef struct packed {
        axis_beat_t beat;
        logic       is_parity;
    } fec_word_t;

    // width of a beat position index within a block of k beats.
    function automatic int loc_wid(input int k);
        return (k > 1) ? $clog2(k) : 1;
    endfunction

endpackage : fec_pkg

// ==== igr_demux.sv ====
`timescale 1ns/1ps

module igr_demux (
    input  logic                 clk,
    input  logic                 rst_n,
    input  fec_pkg::axis_beat_t  in_beat,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  logic                 force_c2h,
    output fec_pkg::axis_beat_t  fec_beat,
    output logic                 fec_valid,
    input  logic                 fec_ready,
    output fec_pkg::axis_beat_t  c2h_beat,
    output logic                 c2h_valid,
    input  logic                 c2h_ready
);
    import fec_pkg::*;

    logic in_pkt;       // inside a packet, path is locked.
    logic sel_c2h;      // locked path of the current packet.
    logic sel_now;

    // first beat decides, later beats follow the locked choice.
    assign sel_now = in_pkt ? sel_c2h : ((in_beat.tdest == port_vf0) || force_c2h);

    assign fec_beat  = in_beat;
    assign c2h_beat  = in_beat;
    assign fec_valid = in_valid && !sel_now;
    assign c2h_valid = in_valid && sel_now;
    assign in_ready  = sel_now ? c2h_ready : fec_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_pkt  <= 1'b0;
            sel_c2h <= 1'b0;
        end else if (in_valid && in_ready) begin
            in_pkt <= !in_beat.tlast;
            if (!in_pkt) begin
                sel_c2h <= sel_now;
            end
        end
    end

endmodule : igr_demux

// ==== pipe_stage.sv ====
`timescale 1ns/1ps

module pipe_stage #(
    parameter type T = fec_pkg::axis_beat_t
) (
    input  logic clk,
    input  logic rst_n,
    input  T     in_data,
    input  logic in_valid,
    output logic in_ready,
    output T     out_data,
    output logic out_valid,
    input  logic out_ready
);

    T     skid_data;
    logic skid_valid;
    logic out_free;     // output register can take a new entry.

    assign in_ready = !skid_valid;  // registered, no path from out_ready.
    assign out_free = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            out_valid  <= skid_valid || in_valid;
            skid_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            skid_valid <= 1'b1;     // output stalled, park the beat.
        end
    end

    // payload registers.
    always_ff @(posedge clk) begin
        if (out_free) begin
            out_data <= skid_valid ? skid_data : in_data;
        end else if (in_valid && in_ready) begin
            skid_data <= in_data;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("pipe_stage: output changed while stalled");

endmodule : pipe_stage

// ==== tb_fec_igr.sv ====
`timescale 1ns/1ps

module tb_fec_igr;
    import fec_pkg::*;

    localparam int NUM_PORTS  = 2;
    localparam int FEC_K      = 4;
    localparam int LOC_WID    = loc_wid(FEC_K);
    localparam int HALF_PER   = 2;          // 4 ns clock.
    localparam int RST_CYC    = 10;
    localparam int NUM_PHASES = 6;
    localparam int PKTS       = 24;         // packets per port and phase.
    localparam int MAX_BLKS   = 4;
    // worst case words per port, parity included.
    localparam int MAX_BEATS  = NUM_PHASES * PKTS * MAX_BLKS * (FEC_K + 1);
    localparam int CYC_MARGIN = 16;         // cycles allowed per word.
    localparam longint WATCHDOG_NS =
        longint'(MAX_BEATS + RST_CYC) * CYC_MARGIN * 2 * HALF_PER;

    logic                 clk = 1'b0;
    logic                 rst_n;
    axis_beat_t           in_beat   [NUM_PORTS];
    logic [NUM_PORTS-1:0] in_valid;
    logic [NUM_PORTS-1:0] in_ready;
    axis_beat_t           out_beat  [NUM_PORTS];
    logic [NUM_PORTS-1:0] out_valid;
    logic [NUM_PORTS-1:0] out_ready;
    axis_beat_t           c2h_beat  [NUM_PORTS];
    logic [NUM_PORTS-1:0] c2h_valid;
    logic [NUM_PORTS-1:0] c2h_ready;
    logic                 force_c2h;
    logic                 err_inj_en;
    logic [LOC_WID-1:0]   err_loc_inj;
    logic [data_wid-1:0]  err_pat;
    logic                 dec_en;
    logic [LOC_WID-1:0]   err_loc_dec;

    integer     seed = 32'h59d3_875f;
    axis_beat_t stim_q    [NUM_PORTS][$];   // beats still to be sent.
    axis_beat_t exp_out_q [NUM_PORTS][$];
    axis_beat_t exp_c2h_q [NUM_PORTS][$];
    int         gen_cnt   [NUM_PORTS];
    int         sent_cnt  [NUM_PORTS];
    int         out_cnt   [NUM_PORTS];
    int         c2h_cnt   [NUM_PORTS];

    always #(HALF_PER) clk = ~clk;

    fec_igr_top #(.NUM_PORTS(NUM_PORTS), .FEC_K(FEC_K)) u_fec_igr_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_beat     (in_beat),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .out_beat    (out_beat),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .c2h_beat    (c2h_beat),
        .c2h_valid   (c2h_valid),
        .c2h_ready   (c2h_ready),
        .force_c2h   (force_c2h),
        .err_inj_en  (err_inj_en),
        .err_loc_inj (err_loc_inj),
        .err_pat     (err_pat),
        .dec_en      (dec_en),
        .err_loc_dec (err_loc_dec)
    );

    task automatic stop_on_error();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_beat(input string name, input int p,
                              input axis_beat_t got, input axis_beat_t exp);
        assert (got == exp) else begin
            $display("error: %0t %s[%0d] expected %h got %h", $time, name, p, exp, got);
            stop_on_error();
        end
    endtask

    function automatic axis_beat_t rand_beat(input logic [dest_wid-1:0] dest,
                                             input logic last);
        axis_beat_t b;
        b.tdata = {$random(seed), $random(seed)};
        b.tkeep = keep_wid'($random(seed));
        b.tid   = id_wid'($random(seed));
        b.tdest = dest;     // same type code on every beat of a packet.
        b.tuser = user_wid'($random(seed));
        b.tlast = last;
        return b;
    endfunction

    // ------------------------------------------------------------------
    // reference model. one packet of whole blocks per call.
    // ------------------------------------------------------------------
    task automatic gen_packet(input int p, input logic to_host_all, input logic inj,
                              input logic [LOC_WID-1:0] loc_inj, input logic [data_wid-1:0] pat,
                              input logic dec, input logic [LOC_WID-1:0] loc_dec);
        int                  n_blk;
        logic [dest_wid-1:0] dest;
        logic                to_host;
        axis_beat_t          blk [FEC_K];
        logic [data_wid-1:0] parity;
        logic [data_wid-1:0] synd;

        n_blk   = 1 + int'($unsigned($random(seed)) % MAX_BLKS);
        dest    = dest_wid'($random(seed));
        to_host = to_host_all || (dest == port_vf0);
        for (int b = 0; b < n_blk; b++) begin
            parity = '0;
            for (int j = 0; j < FEC_K; j++) begin
                blk[j] = rand_beat(dest, (b == n_blk - 1) && (j == FEC_K - 1));
                stim_q[p].push_back(blk[j]);
                parity ^= blk[j].tdata;
            end
            gen_cnt[p] += FEC_K;
            if (to_host) begin
                for (int j = 0; j < FEC_K; j++) exp_c2h_q[p].push_back(blk[j]);
            end else begin
                synd = parity;      // received words xor encoder parity.
                for (int j = 0; j < FEC_K; j++) begin
                    if (inj && (j == int'(loc_inj))) blk[j].tdata ^= pat;
                    synd ^= blk[j].tdata;
                end
                for (int j = 0; j < FEC_K; j++) begin
                    if (dec && (j == int'(loc_dec))) blk[j].tdata ^= synd;
                    exp_out_q[p].push_back(blk[j]);
                end
            end
        end
    endtask

    function automatic logic all_drained();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (stim_q[p].size() != 0 || in_valid[p]) return 1'b0;
            if (exp_out_q[p].size() != 0 || exp_c2h_q[p].size() != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    // config changes only here, with every queue empty.
    task automatic run_phase(input logic to_host_all, input logic inj,
                             input logic [LOC_WID-1:0] loc_inj, input logic [data_wid-1:0] pat,
                             input logic dec, input logic [LOC_WID-1:0] loc_dec);
        @(posedge clk);
        force_c2h   <= to_host_all;
        err_inj_en  <= inj;
        err_loc_inj <= loc_inj;
        err_pat     <= pat;
        dec_en      <= dec;
        err_loc_dec <= loc_dec;
        @(negedge clk);     // packets of this phase, between driver edges.
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int k = 0; k < PKTS; k++) begin
                gen_packet(p, to_host_all, inj, loc_inj, pat, dec, loc_dec);
            end
        end
        do @(negedge clk); while (!all_drained());
    endtask

    // ------------------------------------------------------------------
    // input driver and random back-pressure.
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (in_valid[p] && in_ready[p]) sent_cnt[p]++;
                if (!in_valid[p] || in_ready[p]) begin      // slot is free.
                    if (stim_q[p].size() > 0 && (($random(seed) & 3) != 0)) begin
                        in_beat[p]  <= stim_q[p].pop_front();
                        in_valid[p] <= 1'b1;
                    end else begin
                        in_valid[p] <= 1'b0;
                    end
                end
                out_ready[p] <= 1'($random(seed));
                c2h_ready[p] <= 1'($random(seed));
            end
        end
    end

    // output monitor.
    always @(posedge clk) begin : monitor
        axis_beat_t exp_b;
        if (rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (out_valid[p] && out_ready[p]) begin
                    assert (exp_out_q[p].size() > 0) else begin
                        $display("error: %0t out_beat[%0d] delivered a beat that was never sent",
                                 $time, p);
                        stop_on_error();
                    end
                    exp_b = exp_out_q[p].pop_front();
                    check_beat("out_beat", p, out_beat[p], exp_b);
                    out_cnt[p]++;
                end
                if (c2h_valid[p] && c2h_ready[p]) begin
                    assert (exp_c2h_q[p].size() > 0) else begin
                        $display("error: %0t c2h_beat[%0d] delivered a beat that was never sent",
                                 $time, p);
                        stop_on_error();
                    end
                    exp_b = exp_c2h_q[p].pop_front();
                    check_beat("c2h_beat", p, c2h_beat[p], exp_b);
                    c2h_cnt[p]++;
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("error: watchdog expired at %0t, beats stopped flowing", $time);
        stop_on_error();
    end

    // ------------------------------------------------------------------
    // test sequence.
    // ------------------------------------------------------------------
    initial begin : sequencer
        logic [data_wid-1:0] pat;
        logic [LOC_WID-1:0]  loc;
        logic [LOC_WID-1:0]  loc_alt;
        logic                count_ok;

        rst_n       = 1'b0;
        in_valid    = '0;
        out_ready   = '0;
        c2h_ready   = '0;
        force_c2h   = 1'b0;
        err_inj_en  = 1'b0;
        err_loc_inj = '0;
        err_pat     = '0;
        dec_en      = 1'b0;
        err_loc_dec = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_beat[p]  = '0;
            gen_cnt[p]  = 0;
            sent_cnt[p] = 0;
            out_cnt[p]  = 0;
            c2h_cnt[p]  = 0;
        end
        repeat (RST_CYC) @(posedge clk);
        rst_n <= 1'b1;

        pat     = {$random(seed), $random(seed)} | 64'h1;   // never zero.
        loc     = LOC_WID'($unsigned($random(seed)) % FEC_K);
        loc_alt = LOC_WID'((int'(loc) + 1) % FEC_K);

        run_phase(1'b0, 1'b0, '0, '0, 1'b0, '0);        // forwarding, vf0 packets to host.
        run_phase(1'b1, 1'b0, '0, '0, 1'b0, '0);        // every packet to host.
        run_phase(1'b0, 1'b1, loc, pat, 1'b0, '0);      // corrupted, no repair.
        run_phase(1'b0, 1'b1, loc, pat, 1'b1, loc);     // corrupted and rebuilt.
        run_phase(1'b0, 1'b1, loc, pat, 1'b1, loc_alt); // rebuild at the wrong beat.
        run_phase(1'b0, 1'b0, '0, '0, 1'b1, loc);       // syndrome is zero here.

        count_ok = 1'b1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            assert (sent_cnt[p] == gen_cnt[p] && out_cnt[p] + c2h_cnt[p] == gen_cnt[p]) else begin
                $display("error: %0t port %0d beat count, generated %0d sent %0d received %0d",
                         $time, p, gen_cnt[p], sent_cnt[p], out_cnt[p] + c2h_cnt[p]);
                count_ok = 1'b0;
            end
            // nothing may be left in the lane once every expected beat is out.
            assert (!out_valid[p] && !c2h_valid[p]) else begin
                $display("error: %0t port %0d still offers a beat after the last expected one",
                         $time, p);
                count_ok = 1'b0;
            end
        end
        if (count_ok) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            stop_on_error();
        end
    end

endmodule : tb_fec_igr
